/* verilog/reqrsp_axi_pkg.sv */
// Shared widths, depths and AXI encodings, imported by the adapter RTL and its testbench.
`default_nettype none

package reqrsp_axi_pkg;

    // Bus widths, equal on the reqrsp and AXI sides.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    // Low address bits that select a byte within one bus word.
    localparam int ALIGN_LSB = $clog2(STRB_W);

    // Write queue geometry.
    localparam int WQ_DEPTH = 2;
    localparam int WQ_PTR_W = (WQ_DEPTH > 1) ? $clog2(WQ_DEPTH) : 1;
    localparam int WQ_CNT_W = $clog2(WQ_DEPTH + 1);

    // Reads that may be outstanding without an R response.
    localparam int NUM_PENDING = 4;
    localparam int PEND_W      = $clog2(NUM_PENDING + 1);

    // Fixed burst attributes, since every transfer is a single full-width beat.
    localparam logic [7:0] AXI_LEN        = 8'd0;
    localparam logic [2:0] AXI_SIZE       = 3'(ALIGN_LSB);
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // AXI response codes on B and R.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // Response channel served by the merge stage.
    typedef enum logic {
        ARB_B = 1'b0,
        ARB_R = 1'b1
    } arb_sel_e;

endpackage

`default_nettype wire

/* verilog/wq_if.sv */
// Write-queue push port from the request decoder into the W beat generator.
`timescale 1ns/1ps
`default_nettype none

interface wq_if
    import reqrsp_axi_pkg::*;
();

    // Push strobe, one entry per accepted write.
    logic              push;

    // Payload of the pushed entry.
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;

    // Back-pressure from the queue.
    logic              full;

    // Decoder side.
    modport producer (
        output push,
        output data,
        output strb,
        input  full
    );

    // W stage side.
    modport consumer (
        input  push,
        input  data,
        input  strb,
        output full
    );

endinterface

`default_nettype wire

/* verilog/req_decode.sv */
// Request decode stage, steering reqrsp requests onto AXI AW or AR and counting open reads.
`timescale 1ns/1ps
`default_nettype none

module req_decode
    import reqrsp_axi_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic              q_valid_i,
    input  wire logic              q_write_i,
    input  wire logic [ADDR_W-1:0] q_addr_i,
    input  wire logic [DATA_W-1:0] q_data_i,
    input  wire logic [STRB_W-1:0] q_strb_i,
    input  wire logic [ID_W-1:0]   q_id_i,
    input  wire logic              aw_ready_i,
    input  wire logic              ar_ready_i,
    input  wire logic              read_done_i,
    output logic                   q_ready_o,
    output logic                   aw_valid_o,
    output logic      [ADDR_W-1:0] aw_addr_o,
    output logic      [ID_W-1:0]   aw_id_o,
    output logic                   ar_valid_o,
    output logic      [ADDR_W-1:0] ar_addr_o,
    output logic      [ID_W-1:0]   ar_id_o,
    output logic                   reads_pending_o,
    wq_if.producer                 wq
);

    logic [PEND_W-1:0] pend_cnt_q;
    logic [ADDR_W-1:0] addr_aligned;
    logic              read_room;
    logic              read_accept;

    // Clear the byte offset so the beat covers the whole bus word.
    assign addr_aligned = {q_addr_i[ADDR_W-1:ALIGN_LSB], {ALIGN_LSB{1'b0}}};

    assign read_room = pend_cnt_q < PEND_W'(NUM_PENDING);

    // Writes need a free queue slot, reads need room in the pending count.
    assign aw_valid_o = q_valid_i & q_write_i & ~wq.full;
    assign ar_valid_o = q_valid_i & ~q_write_i & read_room;

    assign aw_addr_o = addr_aligned;
    assign aw_id_o   = q_id_i;
    assign ar_addr_o = addr_aligned;
    assign ar_id_o   = q_id_i;

    always_comb begin
        if (q_write_i) begin
            q_ready_o = aw_ready_i & ~wq.full;
        end else begin
            q_ready_o = ar_ready_i & read_room;
        end
    end

    // The write payload enters the queue together with the AW handshake.
    assign wq.push = q_valid_i & q_ready_o & q_write_i;
    assign wq.data = q_data_i;
    assign wq.strb = q_strb_i;

    assign read_accept = q_valid_i & q_ready_o & ~q_write_i;

    // Count reads issued on AR but not yet answered on R.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_cnt_q <= '0;
        end else if (read_accept && !read_done_i) begin
            pend_cnt_q <= pend_cnt_q + 1'b1;
        end else if (!read_accept && read_done_i) begin
            pend_cnt_q <= pend_cnt_q - 1'b1;
        end
    end

    assign reads_pending_o = |pend_cnt_q;

endmodule

`default_nettype wire

/* verilog/w_beat_gen.sv */
// W channel stage, buffering write data and strobes and issuing one W beat per write.
`timescale 1ns/1ps
`default_nettype none

module w_beat_gen
    import reqrsp_axi_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic              w_ready_i,
    wq_if.consumer                 wq,
    output logic                   w_valid_o,
    output logic      [DATA_W-1:0] w_data_o,
    output logic      [STRB_W-1:0] w_strb_o,
    output logic                   w_last_o
);

    logic [DATA_W-1:0]   data_mem [WQ_DEPTH];
    logic [STRB_W-1:0]   strb_mem [WQ_DEPTH];
    logic [WQ_PTR_W-1:0] wr_ptr_q;
    logic [WQ_PTR_W-1:0] rd_ptr_q;
    logic [WQ_CNT_W-1:0] count_q;
    logic                push;
    logic                pop;

    function automatic logic [WQ_PTR_W-1:0] ptr_next(input logic [WQ_PTR_W-1:0] ptr);
        if (ptr == WQ_PTR_W'(WQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wq.full = count_q == WQ_CNT_W'(WQ_DEPTH);

    assign push = wq.push & ~wq.full;
    assign pop  = w_valid_o & w_ready_i;

    // Storage for queued beats.
    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr_q] <= wq.data;
            strb_mem[wr_ptr_q] <= wq.strb;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // Simultaneous push and pop leave the fill level alone.
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Head of the queue drives W until it is taken.
    assign w_valid_o = count_q != '0;
    assign w_data_o  = data_mem[rd_ptr_q];
    assign w_strb_o  = strb_mem[rd_ptr_q];

    // Single-beat bursts only.
    assign w_last_o = 1'b1;

endmodule

`default_nettype wire

/* verilog/rsp_merge.sv */
// Response stage, merging AXI B and R onto the reqrsp response channel with fair tie-breaking.
`timescale 1ns/1ps
`default_nettype none

module rsp_merge
    import reqrsp_axi_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic              b_valid_i,
    input  wire logic [ID_W-1:0]   b_id_i,
    input  wire axi_resp_e         b_resp_i,
    input  wire logic              r_valid_i,
    input  wire logic [ID_W-1:0]   r_id_i,
    input  wire logic [DATA_W-1:0] r_data_i,
    input  wire axi_resp_e         r_resp_i,
    input  wire logic              p_ready_i,
    input  wire logic              reads_pending_i,
    output logic                   b_ready_o,
    output logic                   r_ready_o,
    output logic                   p_valid_o,
    output logic      [ID_W-1:0]   p_id_o,
    output logic      [DATA_W-1:0] p_data_o,
    output logic                   p_error_o,
    output logic                   read_done_o
);

    arb_sel_e arb_q;
    arb_sel_e held_q;
    arb_sel_e sel;
    logic     hold_q;
    logic     r_avail;
    logic     tie;

    // R only counts while a read is outstanding.
    assign r_avail = r_valid_i & reads_pending_i;
    assign tie     = b_valid_i & r_avail;

    // A stalled response keeps its channel until it is accepted.
    always_comb begin
        if (hold_q) begin
            sel = held_q;
        end else if (tie) begin
            sel = arb_q;
        end else if (r_avail) begin
            sel = ARB_R;
        end else begin
            sel = ARB_B;
        end
    end

    assign p_valid_o = b_valid_i | r_avail;

    always_comb begin
        b_ready_o = 1'b0;
        r_ready_o = 1'b0;
        if (sel == ARB_R) begin
            p_id_o    = r_id_i;
            p_data_o  = r_data_i;
            p_error_o = r_resp_i != RESP_OKAY;
            r_ready_o = r_avail & p_ready_i;
        end else begin
            p_id_o    = b_id_i;
            p_data_o  = '0;
            p_error_o = b_resp_i != RESP_OKAY;
            b_ready_o = b_valid_i & p_ready_i;
        end
    end

    assign read_done_o = r_valid_i & r_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            arb_q  <= ARB_B;
            held_q <= ARB_B;
            hold_q <= 1'b0;
        end else begin
            hold_q <= p_valid_o & ~p_ready_i;
            held_q <= sel;
            // Next tie goes to the channel that lost this one.
            if (tie && p_ready_i) begin
                arb_q <= (sel == ARB_B) ? ARB_R : ARB_B;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/reqrsp_to_axi.sv */
// Top level of the reqrsp to AXI4 adapter, with plain reqrsp and AXI manager ports.
`timescale 1ns/1ps
`default_nettype none

module reqrsp_to_axi
    import reqrsp_axi_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_ni,

    // Reqrsp request channel.
    input  wire logic              q_valid_i,
    output logic                   q_ready_o,
    input  wire logic              q_write_i,
    input  wire logic [ADDR_W-1:0] q_addr_i,
    input  wire logic [DATA_W-1:0] q_data_i,
    input  wire logic [STRB_W-1:0] q_strb_i,
    input  wire logic [ID_W-1:0]   q_id_i,

    // Reqrsp response channel.
    output logic                   p_valid_o,
    input  wire logic              p_ready_i,
    output logic      [ID_W-1:0]   p_id_o,
    output logic      [DATA_W-1:0] p_data_o,
    output logic                   p_error_o,

    // AXI write address.
    output logic                   aw_valid_o,
    input  wire logic              aw_ready_i,
    output logic      [ADDR_W-1:0] aw_addr_o,
    output logic      [ID_W-1:0]   aw_id_o,
    output logic      [7:0]        aw_len_o,
    output logic      [2:0]        aw_size_o,
    output logic      [1:0]        aw_burst_o,

    // AXI write data.
    output logic                   w_valid_o,
    input  wire logic              w_ready_i,
    output logic      [DATA_W-1:0] w_data_o,
    output logic      [STRB_W-1:0] w_strb_o,
    output logic                   w_last_o,

    // AXI write response.
    input  wire logic              b_valid_i,
    output logic                   b_ready_o,
    input  wire logic [ID_W-1:0]   b_id_i,
    input  wire axi_resp_e         b_resp_i,

    // AXI read address.
    output logic                   ar_valid_o,
    input  wire logic              ar_ready_i,
    output logic      [ADDR_W-1:0] ar_addr_o,
    output logic      [ID_W-1:0]   ar_id_o,
    output logic      [7:0]        ar_len_o,
    output logic      [2:0]        ar_size_o,
    output logic      [1:0]        ar_burst_o,

    // AXI read data.
    input  wire logic              r_valid_i,
    output logic                   r_ready_o,
    input  wire logic [ID_W-1:0]   r_id_i,
    input  wire logic [DATA_W-1:0] r_data_i,
    input  wire axi_resp_e         r_resp_i
);

    logic read_done;
    logic reads_pending;

    wq_if u_wq ();

    // Every burst is one full-width incrementing beat.
    assign aw_len_o   = AXI_LEN;
    assign aw_size_o  = AXI_SIZE;
    assign aw_burst_o = AXI_BURST_INCR;
    assign ar_len_o   = AXI_LEN;
    assign ar_size_o  = AXI_SIZE;
    assign ar_burst_o = AXI_BURST_INCR;

    req_decode u_decode (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .q_valid_i       (q_valid_i),
        .q_write_i       (q_write_i),
        .q_addr_i        (q_addr_i),
        .q_data_i        (q_data_i),
        .q_strb_i        (q_strb_i),
        .q_id_i          (q_id_i),
        .aw_ready_i      (aw_ready_i),
        .ar_ready_i      (ar_ready_i),
        .read_done_i     (read_done),
        .q_ready_o       (q_ready_o),
        .aw_valid_o      (aw_valid_o),
        .aw_addr_o       (aw_addr_o),
        .aw_id_o         (aw_id_o),
        .ar_valid_o      (ar_valid_o),
        .ar_addr_o       (ar_addr_o),
        .ar_id_o         (ar_id_o),
        .reads_pending_o (reads_pending),
        .wq              (u_wq)
    );

    w_beat_gen u_w_beat (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .w_ready_i (w_ready_i),
        .wq        (u_wq),
        .w_valid_o (w_valid_o),
        .w_data_o  (w_data_o),
        .w_strb_o  (w_strb_o),
        .w_last_o  (w_last_o)
    );

    rsp_merge u_merge (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .b_valid_i       (b_valid_i),
        .b_id_i          (b_id_i),
        .b_resp_i        (b_resp_i),
        .r_valid_i       (r_valid_i),
        .r_id_i          (r_id_i),
        .r_data_i        (r_data_i),
        .r_resp_i        (r_resp_i),
        .p_ready_i       (p_ready_i),
        .reads_pending_i (reads_pending),
        .b_ready_o       (b_ready_o),
        .r_ready_o       (r_ready_o),
        .p_valid_o       (p_valid_o),
        .p_id_o          (p_id_o),
        .p_data_o        (p_data_o),
        .p_error_o       (p_error_o),
        .read_done_o     (read_done)
    );

endmodule

`default_nettype wire

/* verif/reqrsp_to_axi_props.sv */
// Handshake assertions for the adapter top level, attached to it with bind.
`timescale 1ns/1ps
`default_nettype none

module reqrsp_to_axi_props
    import reqrsp_axi_pkg::*;
(
    input wire logic              clk_i,
    input wire logic              rst_ni,
    input wire logic              aw_valid_o,
    input wire logic              aw_ready_i,
    input wire logic [ADDR_W-1:0] aw_addr_o,
    input wire logic [ID_W-1:0]   aw_id_o,
    input wire logic              ar_valid_o,
    input wire logic              ar_ready_i,
    input wire logic [ADDR_W-1:0] ar_addr_o,
    input wire logic [ID_W-1:0]   ar_id_o,
    input wire logic              w_valid_o,
    input wire logic              w_ready_i,
    input wire logic [DATA_W-1:0] w_data_o,
    input wire logic [STRB_W-1:0] w_strb_o,
    input wire logic              w_last_o,
    input wire logic              p_valid_o,
    input wire logic              p_ready_i,
    input wire logic [ID_W-1:0]   p_id_o,
    input wire logic [DATA_W-1:0] p_data_o,
    input wire logic              p_error_o,
    input wire logic              b_valid_i,
    input wire logic              r_valid_i
);

    // Number of assertion failures seen so far.
    int fail_cnt = 0;

    // A stalled valid keeps its payload.
    aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable({aw_addr_o, aw_id_o}))
        else begin
            $error("AW payload changed under stall");
            fail_cnt++;
        end
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable({ar_addr_o, ar_id_o}))
        else begin
            $error("AR payload changed under stall");
            fail_cnt++;
        end
    w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable({w_data_o, w_strb_o}))
        else begin
            $error("W payload changed under stall");
            fail_cnt++;
        end
    p_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        p_valid_o && !p_ready_i |=> p_valid_o && $stable({p_id_o, p_data_o, p_error_o}))
        else begin
            $error("Response payload changed under stall");
            fail_cnt++;
        end

    last_high: assert property (@(posedge clk_i) disable iff (!rst_ni) w_last_o)
        else begin
            $error("w_last low");
            fail_cnt++;
        end
    p_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
        p_valid_o |-> b_valid_i || r_valid_i)
        else begin
            $error("Response valid without B or R");
            fail_cnt++;
        end

endmodule

bind reqrsp_to_axi reqrsp_to_axi_props u_props (.*);

`default_nettype wire

/* verif/tb_reqrsp_to_axi.sv */
// Directed testbench for the reqrsp to AXI4 adapter, acting as the AXI subordinate.
`timescale 1ns/1ps
`default_nettype none

module tb_reqrsp_to_axi;
    import reqrsp_axi_pkg::*;

    localparam int NUM_TESTS = 6;

    logic clk_i = 1'b0, rst_ni;
    logic q_valid_i, q_ready_o, q_write_i;
    logic [ADDR_W-1:0] q_addr_i;
    logic [DATA_W-1:0] q_data_i;
    logic [STRB_W-1:0] q_strb_i;
    logic [ID_W-1:0] q_id_i;
    logic p_valid_o, p_ready_i, p_error_o;
    logic [ID_W-1:0] p_id_o;
    logic [DATA_W-1:0] p_data_o;
    logic aw_valid_o, aw_ready_i, ar_valid_o, ar_ready_i;
    logic [ADDR_W-1:0] aw_addr_o, ar_addr_o;
    logic [ID_W-1:0] aw_id_o, ar_id_o, b_id_i, r_id_i;
    logic [7:0] aw_len_o, ar_len_o;
    logic [2:0] aw_size_o, ar_size_o;
    logic [1:0] aw_burst_o, ar_burst_o;
    logic w_valid_o, w_ready_i, w_last_o;
    logic [DATA_W-1:0] w_data_o, r_data_i;
    logic [STRB_W-1:0] w_strb_o;
    logic b_valid_i, b_ready_o, r_valid_i, r_ready_o;
    axi_resp_e b_resp_i, r_resp_i;

    integer seed = 36;
    int err_cnt = 0;
    int other_cnt = 0;

    reqrsp_to_axi uut (.*);

    always #5 clk_i = ~clk_i;

    task automatic cmp_data(input logic [DATA_W-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic cmp_id(input logic [ID_W-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // An error flag is expected for every code except OKAY.
    task automatic cmp_resp(input axi_resp_e resp, input logic err, input string what);
        if (err !== (resp != RESP_OKAY)) begin
            $display("Fail at %0t: %s error flag %b for %s", $time, what, err, resp.name());
            err_cnt++;
        end
    endtask

    // Presents one request and plays the AW or AR subordinate with a random stall.
    task automatic issue_req(input logic wr, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                             input logic [ID_W-1:0] id);
        int stall;
        int n;
        stall = {$random(seed)} % 3;
        n = 0;
        aw_ready_i = 1'b0;
        ar_ready_i = 1'b0;
        q_valid_i = 1'b1;
        q_write_i = wr;
        q_addr_i  = addr;
        q_data_i  = data;
        q_strb_i  = strb;
        q_id_i    = id;
        forever begin
            if (n >= stall) {aw_ready_i, ar_ready_i} = 2'b11;
            #1;
            if (q_ready_o || n > 40) break;
            @(negedge clk_i);
            n++;
        end
        if (!q_ready_o) begin
            $display("Request with id %0h was never accepted", id);
            other_cnt++;
        end
        cmp_data(wr ? aw_addr_o : ar_addr_o, {addr[ADDR_W-1:2], 2'b00}, "address");
        cmp_id(wr ? aw_id_o : ar_id_o, id, "address id");
        cmp_data(DATA_W'(wr ? aw_valid_o : ar_valid_o), 1, "address valid");
        cmp_data(DATA_W'(wr ? ar_valid_o : aw_valid_o), 0, "unused address valid");
        // Single-beat INCR bursts of the full bus width.
        cmp_data(DATA_W'(wr ? aw_len_o : ar_len_o), 0, "burst length");
        cmp_data(DATA_W'(wr ? aw_size_o : ar_size_o), $clog2(STRB_W), "burst size");
        cmp_data(DATA_W'(wr ? aw_burst_o : ar_burst_o), 1, "burst type");
        @(negedge clk_i);
        q_valid_i = 1'b0;
    endtask

    task automatic check_w(input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
        int n;
        n = 0;
        #1;
        while (!(w_valid_o && w_ready_i) && n < 20) begin
            @(negedge clk_i);
            #1;
            n++;
        end
        if (!w_valid_o) begin
            $display("Missing W beat for data %h", data);
            other_cnt++;
        end
        cmp_data(w_data_o, data, "w_data");
        cmp_data(DATA_W'(w_strb_o), DATA_W'(strb), "w_strb");
        @(negedge clk_i);
    endtask

    // The idle channel carries a different payload so a wrong merge shows up.
    task automatic send_rsp(input logic is_r, input logic [ID_W-1:0] id,
                            input logic [DATA_W-1:0] data, input axi_resp_e resp);
        axi_resp_e idle_resp;
        if (resp == RESP_OKAY) begin
            idle_resp = RESP_SLVERR;
        end else begin
            idle_resp = RESP_OKAY;
        end
        b_id_i   = is_r ? ~id : id;
        r_id_i   = is_r ? id : ~id;
        r_data_i = is_r ? data : ~data;
        if (is_r) begin
            b_resp_i = idle_resp;
            r_resp_i = resp;
        end else begin
            b_resp_i = resp;
            r_resp_i = idle_resp;
        end
        b_valid_i = ~is_r;
        r_valid_i = is_r;
        p_ready_i = 1'b1;
        #1;
        if (!p_valid_o || !(is_r ? r_ready_o : b_ready_o)) begin
            $display("Response with id %0h never reached the reqrsp side", id);
            other_cnt++;
        end
        cmp_id(p_id_o, id, "p_id");
        cmp_data(p_data_o, is_r ? data : '0, "p_data");
        cmp_resp(resp, p_error_o, is_r ? "R" : "B");
        @(negedge clk_i);
        {b_valid_i, r_valid_i} = 2'b00;
    endtask

    task automatic single_write();
        issue_req(1'b1, 32'h1003, 32'hdeadbeef, 4'h6, 4'h3);
        check_w(32'hdeadbeef, 4'h6);
        send_rsp(1'b0, 4'h3, '0, RESP_OKAY);
    endtask

    task automatic single_read();
        issue_req(1'b0, 32'h2006, '0, '0, 4'h9);
        send_rsp(1'b1, 4'h9, 32'h12345678, RESP_OKAY);
    endtask

    task automatic error_responses();
        issue_req(1'b1, 32'h10, 32'h1, 4'h9, 4'h4);
        check_w(32'h1, 4'h9);
        send_rsp(1'b0, 4'h4, '0, RESP_SLVERR);
        send_rsp(1'b0, 4'h4, '0, RESP_DECERR);
        issue_req(1'b0, 32'h14, '0, '0, 4'h5);
        send_rsp(1'b1, 4'h5, 32'hbad, RESP_SLVERR);
        issue_req(1'b0, 32'h18, '0, '0, 4'h6);
        send_rsp(1'b1, 4'h6, 32'hbad, RESP_DECERR);
    endtask

    task automatic tie_alternation();
        for (int i = 0; i < 2; i++) begin
            issue_req(1'b0, 32'h200, '0, '0, 4'h2);
            {b_valid_i, r_valid_i, b_id_i, r_id_i, r_data_i} = {2'b11, 4'h1, 4'h2, 32'h5};
            b_resp_i = RESP_OKAY;
            r_resp_i = RESP_OKAY;
            // After reset the first tie goes to B, the next to R.
            #1 cmp_id(p_id_o, (i == 0) ? 4'h1 : 4'h2, "first of tie");
            @(negedge clk_i);
            if (i == 0) b_valid_i = 1'b0;
            else r_valid_i = 1'b0;
            #1 cmp_id(p_id_o, (i == 0) ? 4'h2 : 4'h1, "second of tie");
            @(negedge clk_i);
            {b_valid_i, r_valid_i} = 2'b00;
        end
    endtask

    task automatic read_limit();
        for (int i = 0; i < NUM_PENDING; i++) issue_req(1'b0, 32'h300 + 4 * i, '0, '0, 4'(i));
        {q_valid_i, q_write_i, ar_ready_i} = 3'b101;
        #1 cmp_data(DATA_W'(q_ready_o), '0, "q_ready at read limit");
        @(negedge clk_i);
        send_rsp(1'b1, 4'h0, 32'h11, RESP_OKAY);
        #1 cmp_data(DATA_W'(q_ready_o), 1, "q_ready after one R");
        @(negedge clk_i);
        q_valid_i = 1'b0;
        for (int i = 0; i < NUM_PENDING; i++) send_rsp(1'b1, 4'(i), 32'h20 + i, RESP_OKAY);
    endtask

    task automatic backpressure();
        issue_req(1'b0, 32'h400, '0, '0, 4'h7);
        r_valid_i = 1'b1;
        r_id_i    = 4'h7;
        r_data_i  = 32'hcafe;
        r_resp_i  = RESP_OKAY;
        p_ready_i = 1'b0;
        repeat (3) @(negedge clk_i);
        // The stalled R response stays on the reqrsp side.
        cmp_data(DATA_W'(p_valid_o), 1, "p_valid under stall");
        cmp_data(DATA_W'(r_ready_o), 0, "r_ready under stall");
        cmp_id(p_id_o, 4'h7, "p_id under stall");
        cmp_data(p_data_o, 32'hcafe, "p_data under stall");
        send_rsp(1'b1, 4'h7, 32'hcafe, RESP_OKAY);
        w_ready_i = 1'b0;
        issue_req(1'b1, 32'h500, 32'h1, 4'h1, 4'h1);
        issue_req(1'b1, 32'h504, 32'h2, 4'h2, 4'h2);
        q_valid_i  = 1'b1;
        q_write_i  = 1'b1;
        q_addr_i   = 32'h508;
        q_data_i   = 32'h3;
        q_strb_i   = 4'h4;
        q_id_i     = 4'h3;
        aw_ready_i = 1'b1;
        repeat (2) @(negedge clk_i);
        #1 cmp_data(DATA_W'(q_ready_o), '0, "q_ready with full queue");
        cmp_data(w_data_o, 32'h1, "first queued beat");
        @(negedge clk_i);
        w_ready_i = 1'b1;
        @(negedge clk_i);
        #1 cmp_data(DATA_W'(q_ready_o), 1, "q_ready after W beat");
        cmp_data(w_data_o, 32'h2, "second queued beat");
        @(negedge clk_i);
        q_valid_i = 1'b0;
        check_w(32'h3, 4'h4);
    endtask

    initial begin
        #(NUM_TESTS * 2000);
        $display("Timeout: the tests did not finish in time");
        $display("Verification failed");
        $finish;
    end

    initial begin
        {q_valid_i, q_write_i, q_addr_i, q_data_i, q_strb_i, q_id_i} = '0;
        {aw_ready_i, ar_ready_i, w_ready_i, p_ready_i} = 4'b0011;
        {b_valid_i, r_valid_i, b_id_i, r_id_i, r_data_i} = '0;
        b_resp_i = RESP_OKAY;
        r_resp_i = RESP_OKAY;
        rst_ni = 1'b0;
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        single_write();
        single_read();
        error_responses();
        tie_alternation();
        read_limit();
        backpressure();
        $display("Done: %0d mismatches, %0d other failures, %0d assertion failures",
                 err_cnt, other_cnt, uut.u_props.fail_cnt);
        if (err_cnt == 0 && other_cnt == 0 && uut.u_props.fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/reqrsp_axi_pkg.sv
verilog/wq_if.sv
verilog/req_decode.sv
verilog/w_beat_gen.sv
verilog/rsp_merge.sv
verilog/reqrsp_to_axi.sv
verif/reqrsp_to_axi_props.sv
verif/tb_reqrsp_to_axi.sv

/* Bender.yml */
package:
  name: reqrsp_to_axi

sources:
  - files:
      - verilog/reqrsp_axi_pkg.sv
      - verilog/wq_if.sv
      - verilog/req_decode.sv
      - verilog/w_beat_gen.sv
      - verilog/rsp_merge.sv
      - verilog/reqrsp_to_axi.sv
  - target: test
    files:
      - verif/reqrsp_to_axi_props.sv
      - verif/tb_reqrsp_to_axi.sv
